/* sim.f */
+incdir+hw
hw/rf_pkg.sv
hw/wb_if.sv
hw/rf_bank.sv
hw/wb_select.sv
hw/wb_fault_status.sv
hw/rf_subsystem.sv
sim/tb_rf_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# build the register file testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	-f sim.f --top-module tb_rf_subsystem \
	-Mdir obj_dir -o sim_rf &&
out="$(./obj_dir/sim_rf)" &&
printf '%s\n' "$out" &&
printf '%s\n' "$out" | grep -qx "TEST RESULT: PASS" &&
echo "run_sim: simulation passed" && exit 0 ||
{ echo "run_sim: simulation failed"; exit 1; }

/* sim/tb_rf_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none
/*
 * drives rf_subsystem through writebacks, loads, fast-link reads and faults
 * a shadow model tracks every register and reads are checked at the falling edge
 * registers not yet written are skipped since their power-up value is undefined
 */
`include "rf_consts.svh"

module tb_rf_subsystem;

	localparam int CLK_PERIOD = 40;
	localparam int N_RAND     = 40;     // alu/pc/zero cycles
	localparam int N_PORT     = 15;     // three-port iterations of two cycles each
	localparam int STIM_CYCLES = 4 + 31 + 2 + N_RAND + 2 * 7 + `RF_FSL_N + 9
		+ 2 * N_PORT + 2;

	logic        clock;
	logic        rst_n;
	logic [4:0]  ra_addr;
	logic [4:0]  rb_addr;
	logic [4:0]  rd_addr;
	logic [2:0]  sel;
	logic        we_alu;
	logic        we_load;
	logic        enable;
	logic [31:0] result;
	logic [31:0] pc;
	logic [31:0] dmem_data;
	logic [1:0]  dmem_lsb;
	logic [31:0] fsl_data [`RF_FSL_N];
	logic [2:0]  fsl_num;
	logic        fault_clear;
	logic [31:0] ra;
	logic [31:0] rb;
	logic [31:0] rd;
	logic        misalign_seen;
	logic        bad_sel_seen;
	logic [31:0] fault_pc;

	// shadow model state
	logic [31:0] shadow [32];
	logic        known [32];          // register holds a defined value
	logic        exp_mis;
	logic        exp_bad;
	logic [31:0] exp_fpc;

	int          seed = 57;
	int          errors = 0;
	int          checks = 0;
	string       test_name = "reset";
	logic [4:0]  last_rd = 5'd0;      // target of the previous write cycle

	rf_subsystem i_dut (
		.clock         (clock),
		.rst_n         (rst_n),
		.ra_addr       (ra_addr),
		.rb_addr       (rb_addr),
		.rd_addr       (rd_addr),
		.sel           (sel),
		.we_alu        (we_alu),
		.we_load       (we_load),
		.enable        (enable),
		.result        (result),
		.pc            (pc),
		.dmem_data     (dmem_data),
		.dmem_lsb      (dmem_lsb),
		.fsl_data      (fsl_data),
		.fsl_num       (fsl_num),
		.fault_clear   (fault_clear),
		.ra            (ra),
		.rb            (rb),
		.rd            (rd),
		.misalign_seen (misalign_seen),
		.bad_sel_seen  (bad_sel_seen),
		.fault_pc      (fault_pc)
	);

	initial
	begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	// writeback value as the select codes define it with big-endian loads
	function automatic logic [31:0] expected_value(input logic [2:0] s,
		input logic [31:0] word, input logic [1:0] lsb, input logic [31:0] alu,
		input logic [31:0] pcv, input logic [31:0] ch_word);
		logic [31:0] v;
		case (s)
			`RF_SEL_BYTE:
			begin
				case (lsb)
					2'd0: v = {24'd0, word[31:24]};
					2'd1: v = {24'd0, word[23:16]};
					2'd2: v = {24'd0, word[15:8]};
					default: v = {24'd0, word[7:0]};
				endcase
			end
			`RF_SEL_HALF:
				v = (lsb == 2'b00) ? {16'd0, word[31:16]} : {16'd0, word[15:0]};
			`RF_SEL_WORD: v = word;
			`RF_SEL_ALU:  v = alu;
			`RF_SEL_PC:   v = pcv;
			`RF_SEL_FSL:  v = ch_word;
			default:      v = 32'd0;   // zero and the illegal code
		endcase
		return v;
	endfunction

	// model update at each rising edge from the inputs of the ending cycle
	always @(posedge clock)
	begin : model
		logic        wr;
		logic        mis;
		logic        bad;
		logic [31:0] val;
		if (!rst_n)
		begin
			shadow[0] = 32'd0;            // reset clears r0
			known[0]  = 1'b1;
			exp_mis   = 1'b0;
			exp_bad   = 1'b0;
			exp_fpc   = 32'd0;
		end
		else
		begin
			wr  = (we_alu | we_load) & enable & (rd_addr != 5'd0);
			val = expected_value(sel, dmem_data, dmem_lsb, result, pc, fsl_data[fsl_num]);
			mis = wr & (sel == `RF_SEL_HALF) & dmem_lsb[0];
			bad = wr & (sel == 3'd7);
			if ((mis | bad) & !exp_mis & !exp_bad)
				exp_fpc = pc;                 // first fault only
			if (mis)
				exp_mis = 1'b1;
			else if (fault_clear)
				exp_mis = 1'b0;
			if (bad)
				exp_bad = 1'b1;
			else if (fault_clear)
				exp_bad = 1'b0;
			if (wr)
			begin
				shadow[rd_addr] = val;
				known[rd_addr]  = 1'b1;
			end
		end
	end

	always @(negedge clock)
	begin
		if (rst_n)
			checks++;
	end

	function automatic void report_mismatch(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		errors++;
		$display("mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
	endfunction

	// all checks at the falling edge where inputs and reads have settled
	a_read_a: assert property (@(negedge clock) disable iff (!rst_n)
		!known[ra_addr] || (ra === shadow[ra_addr]))
		else report_mismatch("read a", shadow[ra_addr], ra);
	a_read_b: assert property (@(negedge clock) disable iff (!rst_n)
		!known[rb_addr] || (rb === shadow[rb_addr]))
		else report_mismatch("read b", shadow[rb_addr], rb);
	a_read_d: assert property (@(negedge clock) disable iff (!rst_n)
		!known[rd_addr] || (rd === shadow[rd_addr]))
		else report_mismatch("read d", shadow[rd_addr], rd);
	a_misalign_flag: assert property (@(negedge clock) disable iff (!rst_n)
		misalign_seen === exp_mis)
		else report_mismatch("misalign_seen", 32'(exp_mis), 32'(misalign_seen));
	a_bad_sel_flag: assert property (@(negedge clock) disable iff (!rst_n)
		bad_sel_seen === exp_bad)
		else report_mismatch("bad_sel_seen", 32'(exp_bad), 32'(bad_sel_seen));
	a_fault_pc: assert property (@(negedge clock) disable iff (!rst_n)
		fault_pc === exp_fpc)
		else report_mismatch("fault_pc", exp_fpc, fault_pc);

	function automatic logic [31:0] rand_word();
		logic [31:0] r;
		r = $random(seed);
		return r;
	endfunction

	// any register except r0
	function automatic logic [4:0] rand_reg();
		logic [31:0] r;
		r = $random(seed);
		return (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
	endfunction

	// one writeback cycle started 2 ns after a rising edge
	task automatic wb_cycle(input logic [2:0] s, input logic [4:0] a_addr,
		input logic [4:0] b_addr, input logic [4:0] d_addr, input logic alu,
		input logic load, input logic en);
		sel     = s;
		ra_addr = a_addr;
		rb_addr = b_addr;
		rd_addr = d_addr;
		we_alu  = alu;
		we_load = load;
		enable  = en;
		last_rd = d_addr;
		@(posedge clock);
		#2;
	endtask

	initial
	begin : stimulus
		logic [31:0] r;
		logic [4:0]  d;
		logic [4:0]  a;
		logic [4:0]  b;
		rst_n       = 1'b0;
		ra_addr     = 5'd0;
		rb_addr     = 5'd0;
		rd_addr     = 5'd0;
		sel         = `RF_SEL_ZERO;
		we_alu      = 1'b0;
		we_load     = 1'b0;
		enable      = 1'b0;
		result      = 32'd0;
		pc          = 32'd0;
		dmem_data   = 32'd0;
		dmem_lsb    = 2'd0;
		fsl_num     = 3'd0;
		fault_clear = 1'b0;
		for (int i = 0; i < 32; i++)
			known[i] = 1'b0;
		for (int i = 0; i < `RF_FSL_N; i++)
			fsl_data[i] = 32'd0;
		repeat (4) @(posedge clock);
		#2;
		rst_n = 1'b1;

		// fill every register so later reads are all checked
		test_name = "init";
		for (int i = 1; i < 32; i++)
		begin
			result = rand_word();
			wb_cycle(`RF_SEL_ALU, last_rd, last_rd, i[4:0], 1'b1, 1'b0, 1'b1);
		end

		// writes aimed at r0 with either strobe
		test_name = "r0";
		result    = rand_word();
		wb_cycle(`RF_SEL_ALU, 5'd0, 5'd0, 5'd0, 1'b1, 1'b0, 1'b1);
		dmem_data = rand_word();
		wb_cycle(`RF_SEL_WORD, 5'd0, 5'd0, 5'd0, 1'b0, 1'b1, 1'b1);

		// alu, pc and zero with random strobes and enable
		test_name = "alu_pc_zero";
		for (int i = 0; i < N_RAND; i++)
		begin
			r      = rand_word();
			result = rand_word();
			pc     = rand_word();
			case (r[1:0])
				2'd1: wb_cycle(`RF_SEL_PC, last_rd, last_rd, rand_reg(), r[5], r[6],
					r[4:2] != 3'd0);
				2'd2: wb_cycle(`RF_SEL_ZERO, last_rd, last_rd, rand_reg(), r[5], r[6],
					r[4:2] != 3'd0);
				default: wb_cycle(`RF_SEL_ALU, last_rd, last_rd, rand_reg(), r[5], r[6],
					r[4:2] != 3'd0);
			endcase
		end

		// byte loads at every offset, aligned halfwords, whole word
		test_name = "load";
		for (int k = 0; k < 2; k++)
		begin
			dmem_data = rand_word();
			for (int i = 0; i < 4; i++)
			begin
				dmem_lsb = i[1:0];
				wb_cycle(`RF_SEL_BYTE, last_rd, last_rd, rand_reg(), 1'b0, 1'b1, 1'b1);
			end
			dmem_lsb = 2'b00;
			wb_cycle(`RF_SEL_HALF, last_rd, last_rd, rand_reg(), 1'b0, 1'b1, 1'b1);
			dmem_lsb = 2'b10;
			wb_cycle(`RF_SEL_HALF, last_rd, last_rd, rand_reg(), 1'b0, 1'b1, 1'b1);
			dmem_lsb = 2'b00;
			wb_cycle(`RF_SEL_WORD, last_rd, last_rd, rand_reg(), 1'b0, 1'b1, 1'b1);
		end

		test_name = "fsl";
		for (int i = 0; i < `RF_FSL_N; i++)
			fsl_data[i] = rand_word();
		for (int i = 0; i < `RF_FSL_N; i++)
		begin
			fsl_num = i[2:0];
			wb_cycle(`RF_SEL_FSL, last_rd, last_rd, rand_reg(), 1'b1, 1'b0, 1'b1);
		end

		// faults, first pc capture, clear, suppressed faults
		test_name = "fault";
		dmem_data = rand_word();
		dmem_lsb  = 2'b01;
		pc        = 32'h0000_0100;
		wb_cycle(`RF_SEL_HALF, last_rd, last_rd, 5'd5, 1'b0, 1'b1, 1'b1);
		pc = 32'h0000_0200;
		wb_cycle(3'd7, last_rd, last_rd, 5'd6, 1'b1, 1'b0, 1'b1);
		fault_clear = 1'b1;
		wb_cycle(`RF_SEL_ZERO, last_rd, last_rd, 5'd6, 1'b0, 1'b0, 1'b1);
		fault_clear = 1'b0;
		pc          = 32'h0000_0300;
		wb_cycle(`RF_SEL_HALF, last_rd, last_rd, 5'd5, 1'b0, 1'b1, 1'b0);  // enable low
		wb_cycle(3'd7, last_rd, last_rd, 5'd6, 1'b0, 1'b0, 1'b1);          // no strobe
		wb_cycle(3'd7, last_rd, last_rd, 5'd0, 1'b0, 1'b1, 1'b1);          // aimed at r0
		pc = 32'h0000_0400;
		wb_cycle(3'd7, last_rd, last_rd, 5'd7, 1'b1, 1'b0, 1'b1);
		dmem_lsb    = 2'b11;
		fault_clear = 1'b1;        // strobe in the same cycle wins
		wb_cycle(`RF_SEL_HALF, last_rd, last_rd, 5'd8, 1'b0, 1'b1, 1'b1);
		wb_cycle(`RF_SEL_ZERO, last_rd, last_rd, 5'd8, 1'b0, 1'b0, 1'b1);
		fault_clear = 1'b0;

		// reads held across the write edge with some on the write address
		test_name = "three_port";
		for (int i = 0; i < N_PORT; i++)
		begin
			d      = rand_reg();
			a      = (i % 3 == 0) ? d : rand_reg();
			b      = (i % 3 == 1) ? d : rand_reg();
			result = rand_word();
			wb_cycle(`RF_SEL_ALU, a, b, d, 1'b1, 1'b0, 1'b1);
			wb_cycle(`RF_SEL_ALU, a, b, d, 1'b0, 1'b0, 1'b1);  // hold without a write
		end

		test_name = "done";
		wb_cycle(`RF_SEL_ZERO, 5'd0, 5'd0, 5'd0, 1'b0, 1'b0, 1'b0);
		@(negedge clock);
		#1;
		$display("checked %0d cycles, %0d errors", checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// stimulus length plus a margin
	initial
	begin
		#(STIM_CYCLES * CLK_PERIOD + 20 * CLK_PERIOD);
		$display("watchdog expired, the stimulus did not finish in time");
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* hw/rf_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none
/*
 * three-port register file with its writeback path and fault status
 * two banks share the write port, bank a also gives the d read
 * reads are combinational, writes land on the rising edge of clock
 * no fast-link handshake, the channel data is taken as valid
 */
`include "rf_consts.svh"

module rf_subsystem (
	input  logic                          clock,
	input  logic                          rst_n,
	// register addresses from decode
	input  logic [`RF_ADDR_W-1:0]         ra_addr,
	input  logic [`RF_ADDR_W-1:0]         rb_addr,
	input  logic [`RF_ADDR_W-1:0]         rd_addr,
	input  logic [`RF_SEL_W-1:0]          sel,        // writeback source code
	input  logic                          we_alu,     // alu or branch link write
	input  logic                          we_load,    // delayed load write
	input  logic                          enable,     // pipeline advance
	// from execute
	input  logic [`RF_DATA_W-1:0]         result,
	input  logic [`RF_DATA_W-1:0]         pc,
	// from data memory
	input  logic [`RF_DATA_W-1:0]         dmem_data,
	input  logic [1:0]                    dmem_lsb,
	// fast-link channels
	input  logic [`RF_DATA_W-1:0]         fsl_data [`RF_FSL_N],
	input  logic [$clog2(`RF_FSL_N)-1:0]  fsl_num,
	input  logic                          fault_clear,
	// register reads
	output logic [`RF_DATA_W-1:0]         ra,
	output logic [`RF_DATA_W-1:0]         rb,
	output logic [`RF_DATA_W-1:0]         rd,
	// fault status
	output logic                          misalign_seen,
	output logic                          bad_sel_seen,
	output logic [`RF_DATA_W-1:0]         fault_pc
);
	import rf_pkg::*;

	wb_sel_e    sel_t;       // typed select code
	dmem_word_u dmem_u;      // memory word with byte and half views

	assign sel_t  = wb_sel_e'(sel);      // code 7 passes through as illegal
	assign dmem_u = dmem_word_u'(dmem_data);

	wb_if i_wb (
		.clock (clock)
	);

	wb_select i_wb_select (
		.clock     (clock),
		.rst_n     (rst_n),
		.sel       (sel_t),
		.rd_addr   (rd_addr),
		.we_alu    (we_alu),
		.we_load   (we_load),
		.enable    (enable),
		.result    (result),
		.pc        (pc),
		.dmem_data (dmem_u),
		.dmem_lsb  (dmem_lsb),
		.fsl_data  (fsl_data),
		.fsl_num   (fsl_num),
		.wb        (i_wb.src)
	);

	// bank a, read a plus the destination register
	rf_bank i_bank_a (
		.clock     (clock),
		.wr        (i_wb.bank),
		.raddr     (ra_addr),
		.rdata     (ra),
		.wdata_out (rd)
	);

	// bank b, same contents, only read b is used
	rf_bank i_bank_b (
		.clock     (clock),
		.wr        (i_wb.bank),
		.raddr     (rb_addr),
		.rdata     (rb),
		.wdata_out ()
	);

	wb_fault_status i_fault (
		.clock         (clock),
		.rst_n         (rst_n),
		.flt           (i_wb.status),
		.pc            (pc),
		.fault_clear   (fault_clear),
		.misalign_seen (misalign_seen),
		.bad_sel_seen  (bad_sel_seen),
		.fault_pc      (fault_pc)
	);

endmodule

`default_nettype wire

/* hw/wb_fault_status.sv */
`timescale 1ns/1ps
`default_nettype none
/*
 * sticky writeback fault flags and the pc of the first fault
 * flags show up one cycle after the faulting cycle
 * a strobe in the same cycle as fault_clear wins
 */
`include "rf_consts.svh"

module wb_fault_status (
	input  logic                  clock,
	input  logic                  rst_n,
	wb_if.status                  flt,
	input  logic [`RF_DATA_W-1:0] pc,
	input  logic                  fault_clear,
	output logic                  misalign_seen,
	output logic                  bad_sel_seen,
	output logic [`RF_DATA_W-1:0] fault_pc
);

	logic any_strobe;
	logic all_clear;     // nothing recorded yet

	assign any_strobe = flt.misalign | flt.bad_sel;
	assign all_clear  = !misalign_seen & !bad_sel_seen;

	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			misalign_seen <= 1'b0;
			bad_sel_seen  <= 1'b0;
			fault_pc      <= '0;
		end
		else
		begin
			if (flt.misalign)
				misalign_seen <= 1'b1;
			else if (fault_clear)
				misalign_seen <= 1'b0;
			if (flt.bad_sel)
				bad_sel_seen <= 1'b1;
			else if (fault_clear)
				bad_sel_seen <= 1'b0;
			if (any_strobe & all_clear)
				fault_pc <= pc;      // first fault only
		end
	end

	// a flag rises only on its own strobe
	a_misalign_cause: assert property (
		@(posedge clock) disable iff (!rst_n)
		$rose(misalign_seen) |-> $past(flt.misalign)
	);
	a_bad_sel_cause: assert property (
		@(posedge clock) disable iff (!rst_n)
		$rose(bad_sel_seen) |-> $past(flt.bad_sel)
	);

endmodule

`default_nettype wire

/* hw/wb_select.sv */
`timescale 1ns/1ps
`default_nettype none
/*
 * picks the writeback value and gates the register write enable
 * while rst_n is low it writes zero into r0, r0 is never written after
 * loads are big-endian and zero-extended, halfword at offset 01/11
 * takes the lower half and raises misalign
 */
`include "rf_consts.svh"

module wb_select (
	input  logic                          clock,
	input  logic                          rst_n,
	input  rf_pkg::wb_sel_e               sel,
	input  logic [`RF_ADDR_W-1:0]         rd_addr,
	input  logic                          we_alu,
	input  logic                          we_load,
	input  logic                          enable,
	input  logic [`RF_DATA_W-1:0]         result,
	input  logic [`RF_DATA_W-1:0]         pc,
	input  rf_pkg::dmem_word_u            dmem_data,
	input  logic [1:0]                    dmem_lsb,
	input  logic [`RF_DATA_W-1:0]         fsl_data [`RF_FSL_N],
	input  logic [$clog2(`RF_FSL_N)-1:0]  fsl_num,
	wb_if.src                             wb
);
	import rf_pkg::*;

	localparam int DW = `RF_DATA_W;

	logic          want_wr;      // write requested and allowed
	logic          half_idx;     // which half of the word
	logic          half_odd;     // odd byte offset for a halfword
	logic [7:0]    ld_byte;
	logic [15:0]   ld_half;
	logic [DW-1:0] wb_data;      // selected value before reset forcing
	logic          sel_illegal;

	// either strobe, enabled, and never r0
	assign want_wr = (we_alu | we_load) & enable & (|rd_addr);

	// load extraction from the memory word
	assign ld_byte  = dmem_data.bytes[dmem_lsb];   // offset 0 is the msb byte
	assign half_idx = |dmem_lsb;                   // 00 upper, else lower
	assign half_odd = dmem_lsb[0];
	assign ld_half  = dmem_data.halves[half_idx];

	// source mux
	always_comb
	begin
		sel_illegal = 1'b0;
		case (sel)
			WB_SEL_BYTE: wb_data = DW'(ld_byte);       // zero-extend
			WB_SEL_HALF: wb_data = DW'(ld_half);
			WB_SEL_WORD: wb_data = dmem_data;
			WB_SEL_ALU:  wb_data = result;
			WB_SEL_PC:   wb_data = pc;
			WB_SEL_ZERO: wb_data = '0;
			WB_SEL_FSL:  wb_data = fsl_data[fsl_num];  // one of the channels
			default:
			begin
				// code 7, store zero and flag it
				wb_data     = '0;
				sel_illegal = 1'b1;
			end
		endcase
	end

	// write port, reset turns it into a clear of r0
	assign wb.we    = !rst_n | want_wr;
	assign wb.waddr = rst_n ? rd_addr : '0;
	assign wb.wdata = rst_n ? wb_data : '0;

	// fault strobes only for writes that go ahead
	assign wb.misalign = rst_n & want_wr & (sel == WB_SEL_HALF) & half_odd;
	assign wb.bad_sel  = rst_n & want_wr & sel_illegal;

	// r0 stays zero once reset is gone
	a_no_r0_write: assert property (
		@(posedge clock) disable iff (!rst_n) wb.we |-> (wb.waddr != '0)
	);

endmodule

`default_nettype wire

/* hw/rf_bank.sv */
`timescale 1ns/1ps
`default_nettype none
/*
 * one bank of 32 registers, synchronous write and asynchronous reads
 * maps to lut ram, no reset on the contents
 * a write is visible on the reads right after its clock edge
 */
`include "rf_consts.svh"

module rf_bank (
	input  logic                  clock,
	wb_if.bank                    wr,
	input  logic [`RF_ADDR_W-1:0] raddr,
	output logic [`RF_DATA_W-1:0] rdata,
	output logic [`RF_DATA_W-1:0] wdata_out
);

	localparam int DEPTH = 1 << `RF_ADDR_W;

	// register storage
	logic [`RF_DATA_W-1:0] mem [DEPTH];

	// single write port shared with the other bank
	always_ff @(posedge clock)
	begin
		if (wr.we)
			mem[wr.waddr] <= wr.wdata;
	end

	// two async read ports
	assign rdata     = mem[raddr];       // read a or read b
	assign wdata_out = mem[wr.waddr];    // the d register, for stores

	// an unknown address would corrupt some random register
	a_write_known: assert property (
		@(posedge clock) wr.we |-> !$isunknown({wr.waddr, wr.wdata})
	);

endmodule

`default_nettype wire

/* hw/wb_if.sv */
`timescale 1ns/1ps
`default_nettype none
/*
 * write port and fault strobes between writeback select and the banks
 * strobes are single cycle and only fire with a real write
 */
`include "rf_consts.svh"

interface wb_if (
	input logic clock
);
	logic                  we;         // gated write enable
	logic [`RF_ADDR_W-1:0] waddr;      // destination register
	logic [`RF_DATA_W-1:0] wdata;      // value to store
	logic                  misalign;   // odd halfword load strobe
	logic                  bad_sel;    // illegal select strobe

	modport src (output we, waddr, wdata, misalign, bad_sel);
	modport bank (input we, waddr, wdata);      // both banks share it
	modport status (input misalign, bad_sel);

endinterface

`default_nettype wire

/* hw/rf_pkg.sv */
`default_nettype none
/*
 * types shared by the writeback path
 * the select enum leaves code 7 unnamed, it decodes as illegal
 * memory words are big-endian, byte 0 and half 0 sit in the top bits
 */
`include "rf_consts.svh"

package rf_pkg;

	// writeback source select, codes from the consts header
	typedef enum logic [`RF_SEL_W-1:0] {
		WB_SEL_BYTE = `RF_SEL_BYTE,   // zero-extended byte
		WB_SEL_HALF = `RF_SEL_HALF,   // zero-extended halfword
		WB_SEL_WORD = `RF_SEL_WORD,   // full memory word
		WB_SEL_ALU  = `RF_SEL_ALU,
		WB_SEL_PC   = `RF_SEL_PC,     // link value for calls
		WB_SEL_ZERO = `RF_SEL_ZERO,
		WB_SEL_FSL  = `RF_SEL_FSL     // fast-link read
	} wb_sel_e;

	// one data memory word, seen as bytes or as halfwords
	// ascending packed range puts index 0 in the msbs
	typedef union packed {
		logic [0:3][7:0]  bytes;      // bytes[0] = bits 31:24
		logic [0:1][15:0] halves;     // halves[0] = bits 31:16
	} dmem_word_u;

	// both views span the full word
	// load extraction indexes them with the address low bits
	// no sign extension anywhere, signed loads are built in execute

endpackage

`default_nettype wire

/* hw/rf_consts.svh */
/*
 * sizes and writeback select codes for the 32-bit register file
 * select code 7 is illegal and writes zero with a fault strobe
 * the 16-bit datapath is not supported
 */
`ifndef RF_CONSTS_SVH
`define RF_CONSTS_SVH

`define RF_DATA_W   32      // datapath width
`define RF_ADDR_W   5       // 32 registers
`define RF_FSL_N    8       // fast-link input channels
`define RF_SEL_W    3       // writeback select width

// writeback source codes
`define RF_SEL_BYTE 3'd0    // byte load
`define RF_SEL_HALF 3'd1    // halfword load
`define RF_SEL_WORD 3'd2    // whole-word load
`define RF_SEL_ALU  3'd3    // alu result
`define RF_SEL_PC   3'd4    // pc of the instruction
`define RF_SEL_ZERO 3'd5    // constant zero
`define RF_SEL_FSL  3'd6    // fast-link channel word

`endif
